// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --assert -Wno-fatal
TOP       := tb_bundle_frontend
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bundle_fetch.sv
// bundle fetch stage
// holds the bundle address, steps it on accepted bundles, jumps to the vector on commit
module bundle_fetch #(
	parameter int ADDR_W = 32,
	parameter logic [ADDR_W-1:0] RESET_ADDR = '0,
	parameter logic [ADDR_W-1:0] VECTOR_ADDR = '0
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              accept_i,
	input  logic              freeze_i,
	input  logic              int_commit_i,
	output logic [ADDR_W-1:0] fetch_addr_o
);

	logic [ADDR_W-1:0] addr_q;

	// ========================================================================
	// address register
	// ========================================================================
	// commit wins over a step
	// a frozen accept is the injected interrupt bundle, the address stays
	// so the interrupted bundle is fetched again on return
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_q <= RESET_ADDR;
		end else if (int_commit_i) begin
			addr_q <= VECTOR_ADDR;
		end else if (accept_i && !freeze_i) begin
			// one address per bundle
			addr_q <= addr_q + 1'b1;
		end
	end

	// cache sees the address straight from the register
	assign fetch_addr_o = addr_q;

endmodule

// File: bundle_frontend_assertions.sv
// issue stage assertions
// bound into slot_issue, covers reset, the commit pulse and the shape of queued_on
module bundle_frontend_assertions (
	input logic                          clk,
	input logic                          rst,
	input logic                          issue_valid_i,
	input logic                          int_commit_i,
	input logic [bundle_pkg::NSLOTS-1:0] queued_on_i
);

	// pending is cleared by the first reset edge, nothing may issue after it
	a_no_issue_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !issue_valid_i)
		else $error("issue_valid_o high while in reset");

	// a commit flushes its bundle, so the break cannot commit twice
	a_commit_one_cycle: assert property (@(posedge clk) disable iff (rst)
		int_commit_i |=> !int_commit_i)
		else $error("int_commit_o held for more than one cycle");

	// one slot retires, or a flush clears all of them
	a_queued_shape: assert property (@(posedge clk) disable iff (rst)
		issue_valid_i |-> ($onehot(queued_on_i) || (&queued_on_i)))
		else $error("queued_on_o neither one-hot nor all ones");

endmodule

bind slot_issue bundle_frontend_assertions assertions_i (
	.clk           (clk),
	.rst           (rst),
	.issue_valid_i (issue_valid_o),
	.int_commit_i  (int_commit_o),
	.queued_on_i   (queued_on_o)
);

// File: bundle_frontend_top.sv
// bundle front end top level
// fetch, predecode buffer with code buffer, and slot issue
module bundle_frontend_top #(
	parameter int ADDR_W = 32,
	parameter logic [ADDR_W-1:0] RESET_ADDR = 32'h0000_0100,
	parameter logic [ADDR_W-1:0] VECTOR_ADDR = 32'h0000_0120
) (
	input  logic                clk,
	input  logic                rst,
	input  bundle_pkg::bundle_t ic_out_i,
	input  logic                phit_i,
	input  bundle_pkg::fault_e  ic_fault_i,
	input  logic [3:0]          irq_i,
	input  logic [3:0]          im_i,
	input  logic [7:0]          cause_i,
	input  logic                cb_we_i,
	input  logic [5:0]          cb_addr_i,
	input  bundle_pkg::insn_t   cb_data_i,
	output logic [ADDR_W-1:0]   fetch_addr_o,
	output logic                issue_valid_o,
	output logic [1:0]          issue_slot_o,
	output bundle_pkg::insn_t   issue_insn_o
);

	logic freeze;
	logic next_bundle;
	logic int_commit;
	logic [bundle_pkg::NSLOTS-1:0] queued_on;
	logic [bundle_pkg::NSLOTS-1:0][5:0] cb_index;
	bundle_pkg::insn_t [bundle_pkg::NSLOTS-1:0] cb_rdata;
	bundle_pkg::bundle_t bundle;

	// ========================================================================
	// stages
	// ========================================================================
	bundle_fetch #(
		.ADDR_W      (ADDR_W),
		.RESET_ADDR  (RESET_ADDR),
		.VECTOR_ADDR (VECTOR_ADDR)
	) bundle_fetch_i (
		.clk          (clk),
		.rst          (rst),
		.accept_i     (phit_i & next_bundle),
		.freeze_i     (freeze),
		.int_commit_i (int_commit),
		.fetch_addr_o (fetch_addr_o)
	);

	exec_code_buffer exec_code_buffer_i (
		.clk     (clk),
		.rst     (rst),
		.we_i    (cb_we_i),
		.waddr_i (cb_addr_i),
		.wdata_i (cb_data_i),
		.raddr_i (cb_index),
		.rdata_o (cb_rdata)
	);

	decode_buffer decode_buffer_i (
		.clk           (clk),
		.rst           (rst),
		.irq_i         (irq_i),
		.im_i          (im_i),
		.cause_i       (cause_i),
		.int_commit_i  (int_commit),
		.ic_fault_i    (ic_fault_i),
		.ic_out_i      (ic_out_i),
		.phit_i        (phit_i),
		.next_bundle_i (next_bundle),
		.queued_on_i   (queued_on),
		.cb_rdata_i    (cb_rdata),
		.cb_raddr_o    (cb_index),
		.freeze_o      (freeze),
		.bundle_o      (bundle)
	);

	slot_issue slot_issue_i (
		.clk           (clk),
		.rst           (rst),
		.bundle_i      (bundle),
		.queued_on_o   (queued_on),
		.next_bundle_o (next_bundle),
		.int_commit_o  (int_commit),
		.issue_valid_o (issue_valid_o),
		.issue_slot_o  (issue_slot_o),
		.issue_insn_o  (issue_insn_o)
	);

endmodule

// File: bundle_pkg.sv
// bundle front end shared definitions
// instruction and bundle formats, opcode and cause encodings, NOP and break helpers
package bundle_pkg;

	// slots per bundle and code buffer depth (rs1 is 6 bits wide)
	localparam int NSLOTS = 3;
	localparam int CB_DEPTH = 64;

	// ========================================================================
	// encodings
	// ========================================================================
	typedef enum logic [5:0] {
		OP_NOP   = 6'h3d,
		OP_ALU   = 6'h04,
		OP_BRK   = 6'h00,
		OP_BMISC = 6'h01
	} opcode_e;

	typedef enum logic [4:0] {
		F_NONE = 5'd0,
		F_INT  = 5'd1,
		F_PFI  = 5'd2,
		F_EXEC = 5'd3
	} funct5_e;

	// fault causes, hardware interrupts carry cause_i as is
	typedef enum logic [7:0] {
		CAUSE_NONE = 8'h00,
		FLT_TLB    = 8'h04,
		FLT_EXF    = 8'h05,
		FLT_IBE    = 8'h06
	} cause_e;

	// fault code returned by the instruction cache
	typedef enum logic [1:0] {
		FAULT_NONE = 2'd0,
		FAULT_TLB  = 2'd1,
		FAULT_EXF  = 2'd2,
		FAULT_IBE  = 2'd3
	} fault_e;

	// ========================================================================
	// formats
	// ========================================================================
	// 41-bit instruction, opcode in the top bits
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  funct5;
		logic [5:0]  rs1;
		logic [7:0]  cause;
		logic [3:0]  irq;
		logic [11:0] imm;
	} insn_t;

	// 128-bit bundle, pending has one bit per slot
	typedef struct packed {
		logic [1:0] pad;
		logic [2:0] pending;
		insn_t      slot2;
		insn_t      slot1;
		insn_t      slot0;
	} bundle_t;

	localparam insn_t NOP_INSN = '{opcode: OP_NOP, default: '0};

	// break-interrupt instruction for a cause and irq level
	function automatic insn_t make_int_insn(input logic [7:0] cause, input logic [3:0] irq);
		insn_t insn;
		insn = '0;
		insn.opcode = OP_BRK;
		insn.funct5 = F_INT;
		insn.cause = cause;
		insn.irq = irq;
		return insn;
	endfunction

endpackage

// File: decode_buffer.sv
// predecode stage and bundle register
// injects interrupts and faults, converts PFI, substitutes EXEC targets
module decode_buffer (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic [3:0]                                  irq_i,
	input  logic [3:0]                                  im_i,
	input  logic [7:0]                                  cause_i,
	input  logic                                        int_commit_i,
	input  bundle_pkg::fault_e                          ic_fault_i,
	input  bundle_pkg::bundle_t                         ic_out_i,
	input  logic                                        phit_i,
	input  logic                                        next_bundle_i,
	input  logic [bundle_pkg::NSLOTS-1:0]               queued_on_i,
	input  bundle_pkg::insn_t [bundle_pkg::NSLOTS-1:0] cb_rdata_i,
	output logic [bundle_pkg::NSLOTS-1:0][5:0]          cb_raddr_o,
	output logic                                        freeze_o,
	output bundle_pkg::bundle_t                         bundle_o
);

	bundle_pkg::insn_t [bundle_pkg::NSLOTS-1:0] raw;
	bundle_pkg::insn_t [bundle_pkg::NSLOTS-1:0] pre;
	bundle_pkg::insn_t int_insn;
	bundle_pkg::cause_e fault_cause;
	logic kill;
	bundle_pkg::bundle_t bundle_q;

	function automatic logic is_pfi(input bundle_pkg::insn_t insn);
		return bundle_pkg::opcode_e'(insn.opcode) == bundle_pkg::OP_BRK &&
			bundle_pkg::funct5_e'(insn.funct5) == bundle_pkg::F_PFI;
	endfunction

	function automatic logic is_exec(input bundle_pkg::insn_t insn);
		return bundle_pkg::opcode_e'(insn.opcode) == bundle_pkg::OP_BMISC &&
			bundle_pkg::funct5_e'(insn.funct5) == bundle_pkg::F_EXEC;
	endfunction

	// slot 0 sits in the low bits
	assign raw = {ic_out_i.slot2, ic_out_i.slot1, ic_out_i.slot0};

	// each slot looks up its own rs1, used only if the slot is an EXEC
	always_comb begin
		for (int i = 0; i < bundle_pkg::NSLOTS; i++) begin
			cb_raddr_o[i] = raw[i].rs1;
		end
	end

	// hold the fetch address while an interrupt waits to be taken
	// released in the commit cycle so fetch can load the vector
	assign freeze_o = (irq_i > im_i) && !int_commit_i;

	assign int_insn = bundle_pkg::make_int_insn(cause_i, irq_i);

	// ========================================================================
	// fault decode
	// ========================================================================
	always_comb begin
		case (ic_fault_i)
			bundle_pkg::FAULT_TLB: fault_cause = bundle_pkg::FLT_TLB;
			bundle_pkg::FAULT_EXF: fault_cause = bundle_pkg::FLT_EXF;
			bundle_pkg::FAULT_IBE: fault_cause = bundle_pkg::FLT_IBE;
			// an all-zero bundle means nothing came back from the bus
			default: fault_cause = (ic_out_i == '0) ? bundle_pkg::FLT_IBE : bundle_pkg::CAUSE_NONE;
		endcase
	end

	// ========================================================================
	// predecode
	// ========================================================================
	always_comb begin
		pre = raw;
		kill = 1'b0;
		if (freeze_o) begin
			// whole bundle becomes the interrupt
			pre = {bundle_pkg::NSLOTS{int_insn}};
		end else if (fault_cause != bundle_pkg::CAUSE_NONE) begin
			pre = {bundle_pkg::NSLOTS{bundle_pkg::make_int_insn(fault_cause, 4'h0)}};
		end else begin
			for (int i = 0; i < bundle_pkg::NSLOTS; i++) begin
				if (kill) begin
					// slots behind a taken PFI never run
					pre[i] = bundle_pkg::NOP_INSN;
				end else if (is_pfi(raw[i])) begin
					if (irq_i == 4'h0) begin
						pre[i] = bundle_pkg::NOP_INSN;
					end else begin
						pre[i] = int_insn;
						kill = 1'b1;
					end
				end else if (is_exec(raw[i])) begin
					pre[i] = cb_rdata_i[i];
				end
			end
		end
	end

	// ========================================================================
	// bundle register
	// ========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			bundle_q.pad <= '0;
			bundle_q.pending <= '0;
			bundle_q.slot2 <= bundle_pkg::NOP_INSN;
			bundle_q.slot1 <= bundle_pkg::NOP_INSN;
			bundle_q.slot0 <= bundle_pkg::NOP_INSN;
		end else if (phit_i && next_bundle_i) begin
			// new bundle, every slot waits to issue
			bundle_q.pad <= '0;
			bundle_q.pending <= '1;
			bundle_q.slot2 <= pre[2];
			bundle_q.slot1 <= pre[1];
			bundle_q.slot0 <= pre[0];
		end else begin
			// retire issued or flushed slots
			bundle_q.pending <= bundle_q.pending & ~queued_on_i;
		end
	end

	assign bundle_o = bundle_q;

endmodule

// File: exec_code_buffer.sv
// EXEC code buffer
// 64 instruction entries, one write port and one read port per slot
module exec_code_buffer (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        we_i,
	input  logic [5:0]                                  waddr_i,
	input  bundle_pkg::insn_t                           wdata_i,
	input  logic [bundle_pkg::NSLOTS-1:0][5:0]          raddr_i,
	output bundle_pkg::insn_t [bundle_pkg::NSLOTS-1:0] rdata_o
);

	bundle_pkg::insn_t mem [bundle_pkg::CB_DEPTH];

	// entries come up as NOPs so an unwritten EXEC target is harmless
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < bundle_pkg::CB_DEPTH; i++) begin
				mem[i] <= bundle_pkg::NOP_INSN;
			end
		end else if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// combinational reads, one per slot
	always_comb begin
		for (int i = 0; i < bundle_pkg::NSLOTS; i++) begin
			rdata_o[i] = mem[raddr_i[i]];
		end
	end

endmodule

// File: list.f
bundle_pkg.sv
bundle_fetch.sv
exec_code_buffer.sv
decode_buffer.sv
slot_issue.sv
bundle_frontend_top.sv
bundle_frontend_assertions.sv
tb_bundle_frontend.sv

// File: slot_issue.sv
// slot issue stage
// issues the lowest pending slot per cycle, commits break interrupts
module slot_issue (
	input  logic                          clk,
	input  logic                          rst,
	input  bundle_pkg::bundle_t           bundle_i,
	output logic [bundle_pkg::NSLOTS-1:0] queued_on_o,
	output logic                          next_bundle_o,
	output logic                          int_commit_o,
	output logic                          issue_valid_o,
	output logic [1:0]                    issue_slot_o,
	output bundle_pkg::insn_t             issue_insn_o
);

	bundle_pkg::insn_t [bundle_pkg::NSLOTS-1:0] slots;
	logic [bundle_pkg::NSLOTS-1:0] pending;
	logic [bundle_pkg::NSLOTS-1:0] sel_onehot;
	logic [bundle_pkg::NSLOTS-1:0] rest;
	logic [1:0] sel;
	logic is_int;

	assign slots = {bundle_i.slot2, bundle_i.slot1, bundle_i.slot0};
	assign pending = bundle_i.pending;

	// ========================================================================
	// priority select
	// ========================================================================
	// walk down so the lowest set bit wins
	always_comb begin
		sel = '0;
		for (int i = bundle_pkg::NSLOTS - 1; i >= 0; i--) begin
			if (pending[i]) begin
				sel = 2'(i);
			end
		end
	end

	// isolate lowest set bit
	assign sel_onehot = pending & (~pending + 3'd1);
	assign rest = pending & ~sel_onehot;

	assign issue_valid_o = |pending;
	assign issue_slot_o = sel;
	assign issue_insn_o = slots[sel];

	// break-interrupt, covers irq, PFI and fault breaks alike
	assign is_int = issue_valid_o &&
		bundle_pkg::opcode_e'(issue_insn_o.opcode) == bundle_pkg::OP_BRK &&
		bundle_pkg::funct5_e'(issue_insn_o.funct5) == bundle_pkg::F_INT;

	// ========================================================================
	// commit and flush
	// ========================================================================
	// the flush empties the bundle, so the commit lasts a single cycle
	assign int_commit_o = is_int;

	// a break throws away the rest of its bundle
	assign queued_on_o = is_int ? '1 : sel_onehot;

	// last slot going out, or nothing left
	// a committing break holds off one cycle so the old address is not accepted
	assign next_bundle_o = ~|rest && !is_int;

endmodule

// File: tb_bundle_frontend.sv
// directed testbench for the bundle front end
// same-cycle cache model, one task per behavior, stops at the first mismatch
module tb_bundle_frontend;

	localparam logic [31:0] RESET_ADDR = 32'h0000_0100;
	localparam logic [31:0] VECTOR_ADDR = 32'h0000_0120;
	// cache index of the vector bundle
	localparam int VEC_IDX = 32;
	localparam int TIMEOUT = 40;
	localparam bundle_pkg::insn_t NOP_EXPECT = {6'(bundle_pkg::OP_NOP), 35'd0};

	logic clk = 1'b0;
	logic rst;
	bundle_pkg::bundle_t ic_out_i;
	logic phit_i;
	bundle_pkg::fault_e ic_fault_i;
	logic [3:0] irq_i;
	logic [3:0] im_i;
	logic [7:0] cause_i;
	logic cb_we_i;
	logic [5:0] cb_addr_i;
	bundle_pkg::insn_t cb_data_i;
	logic [31:0] fetch_addr_o;
	logic issue_valid_o;
	logic [1:0] issue_slot_o;
	bundle_pkg::insn_t issue_insn_o;

	// cache model, one bundle per address counted from RESET_ADDR
	bundle_pkg::bundle_t cache_mem [64];
	logic [31:0] rng_state;

	always #2 clk = ~clk;

	// answers in the same cycle as the address
	assign ic_out_i = cache_mem[6'(fetch_addr_o - RESET_ADDR)];

	bundle_frontend_top #(
		.ADDR_W      (32),
		.RESET_ADDR  (RESET_ADDR),
		.VECTOR_ADDR (VECTOR_ADDR)
	) bundle_frontend_top_i (.*);

	// ========================================================================
	// stimulus helpers
	// ========================================================================
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	// ALU or NOP with random fields, never a PFI or EXEC
	function automatic bundle_pkg::insn_t rand_insn();
		logic [31:0] a;
		logic [31:0] b;
		bundle_pkg::insn_t insn;
		a = next_rand();
		b = next_rand();
		insn = {a[31:11], b[31:12]};
		insn.opcode = a[7] ? bundle_pkg::OP_ALU : bundle_pkg::OP_NOP;
		return insn;
	endfunction

	// PFI or EXEC carrying random leftover fields
	function automatic bundle_pkg::insn_t special_insn(input logic [5:0] op, input logic [4:0] fn,
		input logic [5:0] idx);
		bundle_pkg::insn_t insn;
		insn = rand_insn();
		insn.opcode = op;
		insn.funct5 = fn;
		insn.rs1 = idx;
		return insn;
	endfunction

	// expected break, fields in format order opcode funct5 rs1 cause irq imm
	function automatic bundle_pkg::insn_t break_insn(input logic [7:0] cause, input logic [3:0] irq);
		return {6'(bundle_pkg::OP_BRK), 5'(bundle_pkg::F_INT), 6'd0, cause, irq, 12'd0};
	endfunction

	function automatic bundle_pkg::insn_t slot_of(input bundle_pkg::bundle_t b, input int s);
		case (s)
			0: return b.slot0;
			1: return b.slot1;
			default: return b.slot2;
		endcase
	endfunction

	task automatic fill_cache();
		for (int i = 0; i < 64; i++) begin
			cache_mem[i] = '0;
			cache_mem[i].slot0 = rand_insn();
			cache_mem[i].slot1 = rand_insn();
			cache_mem[i].slot2 = rand_insn();
		end
	endtask

	// inputs move 1 unit after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic expect_issue(input int slot, input bundle_pkg::insn_t insn);
		check_value("issue valid", 64'(issue_valid_o), 64'd1);
		check_value("issue slot", 64'(issue_slot_o), 64'(slot));
		check_value("issued instruction", 64'(issue_insn_o), 64'(insn));
	endtask

	task automatic wait_issue();
		int cycles;
		cycles = 0;
		step();
		while (!issue_valid_o && cycles < TIMEOUT) begin
			step();
			cycles++;
		end
		if (!issue_valid_o) begin
			$display("no instruction issued within %0d cycles", TIMEOUT);
			$display("Testbench failed");
			$fatal(1, "issue wait timed out");
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		phit_i = 1'b0;
		ic_fault_i = bundle_pkg::FAULT_NONE;
		irq_i = '0;
		im_i = '0;
		cause_i = '0;
		cb_we_i = 1'b0;
		fill_cache();
		repeat (16) step();
		rst = 1'b0;
	endtask

	// commit loads the vector at the next edge and flushes the rest of the bundle
	// then the vector bundle starts at slot 0
	task automatic expect_vector_redirect();
		step();
		check_value("valid after commit", 64'(issue_valid_o), 64'd0);
		check_value("fetch address after commit", 64'(fetch_addr_o), 64'(VECTOR_ADDR));
		wait_issue();
		expect_issue(0, cache_mem[VEC_IDX].slot0);
		check_value("fetch address past vector", 64'(fetch_addr_o), 64'(VECTOR_ADDR + 1));
	endtask

	// ========================================================================
	// behaviors
	// ========================================================================
	task automatic check_reset_state();
		apply_reset();
		repeat (3) begin
			check_value("valid after reset", 64'(issue_valid_o), 64'd0);
			check_value("fetch address after reset", 64'(fetch_addr_o), 64'(RESET_ADDR));
			step();
		end
	endtask

	task automatic run_plain_stream();
		apply_reset();
		phit_i = 1'b1;
		wait_issue();
		// one instruction per cycle across bundle boundaries
		for (int b = 0; b < 4; b++) begin
			for (int s = 0; s < 3; s++) begin
				if (b != 0 || s != 0) begin
					step();
				end
				expect_issue(s, slot_of(cache_mem[b], s));
				check_value("fetch address", 64'(fetch_addr_o), 64'(RESET_ADDR + b + 1));
			end
		end
	endtask

	task automatic run_exec_substitution();
		bundle_pkg::insn_t target;
		logic [5:0] k;
		apply_reset();
		target = rand_insn();
		k = 6'(next_rand() >> 26);
		cb_we_i = 1'b1;
		cb_addr_i = k;
		cb_data_i = target;
		step();
		cb_we_i = 1'b0;
		// slot 2 names an entry never written, still a NOP from reset
		cache_mem[0].slot1 = special_insn(bundle_pkg::OP_BMISC, bundle_pkg::F_EXEC, k);
		cache_mem[0].slot2 = special_insn(bundle_pkg::OP_BMISC, bundle_pkg::F_EXEC, k ^ 6'd1);
		phit_i = 1'b1;
		wait_issue();
		expect_issue(0, cache_mem[0].slot0);
		step();
		expect_issue(1, target);
		step();
		expect_issue(2, NOP_EXPECT);
	endtask

	task automatic pfi_as_nop();
		apply_reset();
		cache_mem[0].slot0 = special_insn(bundle_pkg::OP_BRK, bundle_pkg::F_PFI, 6'd0);
		phit_i = 1'b1;
		wait_issue();
		expect_issue(0, NOP_EXPECT);
		step();
		expect_issue(1, cache_mem[0].slot1);
		step();
		expect_issue(2, cache_mem[0].slot2);
	endtask

	// irq pending but masked, only the PFI takes it
	task automatic pfi_takes_interrupt();
		apply_reset();
		irq_i = 4'd2;
		im_i = 4'd5;
		cause_i = 8'h3c;
		cache_mem[0].slot1 = special_insn(bundle_pkg::OP_BRK, bundle_pkg::F_PFI, 6'd0);
		phit_i = 1'b1;
		wait_issue();
		expect_issue(0, cache_mem[0].slot0);
		step();
		expect_issue(1, break_insn(8'h3c, 4'd2));
		expect_vector_redirect();
	endtask

	task automatic hardware_interrupt();
		apply_reset();
		irq_i = 4'd6;
		im_i = 4'd2;
		cause_i = 8'h5a;
		phit_i = 1'b1;
		wait_issue();
		expect_issue(0, break_insn(8'h5a, 4'd6));
		// frozen fetch keeps the interrupted address
		check_value("fetch address while frozen", 64'(fetch_addr_o), 64'(RESET_ADDR));
		// handler raises the mask
		im_i = 4'hf;
		expect_vector_redirect();
	endtask

	task automatic fault_break(input bundle_pkg::fault_e code, input bundle_pkg::cause_e cause);
		apply_reset();
		ic_fault_i = code;
		phit_i = 1'b1;
		wait_issue();
		expect_issue(0, break_insn(cause, 4'd0));
		ic_fault_i = bundle_pkg::FAULT_NONE;
		expect_vector_redirect();
	endtask

	// empty bus response counts as a bus error
	task automatic zero_bundle_break();
		apply_reset();
		cache_mem[0] = '0;
		phit_i = 1'b1;
		wait_issue();
		expect_issue(0, break_insn(bundle_pkg::FLT_IBE, 4'd0));
		expect_vector_redirect();
	endtask

	// ========================================================================
	// sequence
	// ========================================================================
	initial begin
		rst = 1'b1;
		phit_i = 1'b0;
		ic_fault_i = bundle_pkg::FAULT_NONE;
		irq_i = '0;
		im_i = '0;
		cause_i = '0;
		cb_we_i = 1'b0;
		cb_addr_i = '0;
		cb_data_i = '0;
		rng_state = 32'd57339;
		fill_cache();
		check_reset_state();
		run_plain_stream();
		run_exec_substitution();
		pfi_as_nop();
		pfi_takes_interrupt();
		hardware_interrupt();
		fault_break(bundle_pkg::FAULT_TLB, bundle_pkg::FLT_TLB);
		fault_break(bundle_pkg::FAULT_EXF, bundle_pkg::FLT_EXF);
		fault_break(bundle_pkg::FAULT_IBE, bundle_pkg::FLT_IBE);
		zero_bundle_break();
		$display("Testbench passed");
		$finish;
	end

endmodule
